//--- vlog.f
+incdir+common
common/ctrl_flow_pkg.sv
common/data_flow_pkg.sv
design/operand_forward.sv
design/exec_unit.sv
backend/stage_ctrl_regs.sv
backend/stage_data_regs.sv
backend/backend_pipeline.sv
dv/backend_checker.sv
dv/tb_backend.sv

//--- run.sh
#!/bin/sh
# build and run the backend testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f vlog.f --top-module tb_backend -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_backend)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
	exit 0
fi
exit 1

//--- dv/backend_vectors.txt
// hex: issue stall clr alu_op use_imm w_reg revert fwd0 fwd1 imm pc rs1 rs2
//      pipe1_m1 pipe1_m2 pipe1_wb, expected reg_w_addr reg_w_data revert_vector
0 0 0 0 0 00 0 000 000 0        0   0        0  0        0    0        00 0        0
1 0 0 0 0 01 0 000 000 0        100 5        3  0        0    0        00 0        0
1 0 0 1 0 02 0 000 000 0        104 a        3  0        0    0        00 0        0
1 0 0 2 0 03 1 000 000 0        108 f0       3c 0        0    0        00 0        0
1 0 0 3 1 04 0 000 000 f        10c f0       5  0        0    0        00 0        1
1 0 0 4 0 05 0 000 000 0        110 ff       f  0        0    0        01 8        2
1 0 0 5 0 06 0 000 000 0        114 ffffffff 1  0        0    0        02 7        4
1 0 0 6 0 07 0 000 000 0        118 ffffffff 1  0        0    0        03 30       8
1 0 0 7 0 08 0 000 000 12345000 11c 0        0  0        0    0        04 ff       0
1 0 0 8 0 09 0 000 000 0        200 0        0  0        0    0        05 f0       0
// forwarding from own pipe, then from pipe 1
1 0 0 0 0 0a 0 040 000 0        204 0        1  0        0    0        06 1        0
1 0 0 0 0 0b 0 080 100 0        208 0        0  0        0    0        07 0        0
1 0 0 4 0 0c 0 240 300 0        20c 0        0  0        0    0        08 12345000 0
1 0 0 1 0 0d 0 280 000 0        210 0        1  aaaa0000 dead 0000bbbb 09 204      0
// ex stall while the producer moves m1, m2, wb
1 0 0 0 0 0e 0 000 000 0        214 40       2  0        100  0        0a 205      0
1 0 0 0 0 0f 1 040 000 0        218 7777     1  0        0    0        0b 12345204 0
0 1 0 0 0 00 0 000 000 0        0   0        0  0        0    0        0c aaaabbbb 1
0 1 0 0 0 00 0 000 000 0        0   0        0  0        0    0        0d ff       1
0 1 0 0 0 00 0 000 000 0        0   0        0  0        0    0        0e 42       1
// clear ex, then clear m1
1 0 0 0 0 10 0 000 000 0        300 1        1  0        0    0        00 0        1
1 0 1 0 0 11 0 000 000 0        304 2        2  0        0    0        00 0        2
1 0 0 3 0 12 0 000 000 0        308 5        a  0        0    0        00 0        4
0 0 2 0 0 00 0 000 000 0        0   0        0  0        0    0        0f 43       8
0 0 0 0 0 00 0 000 000 0        0   0        0  0        0    0        00 0        0
0 0 0 0 0 00 0 000 000 0        0   0        0  0        0    0        00 0        0
0 0 0 0 0 00 0 000 000 0        0   0        0  0        0    0        12 f        0

//--- dv/tb_backend.sv
`include "backend_settings.svh"

module tb_backend;

	localparam int NUM_VEC  = 26;
	localparam int VEC_COLS = 19; // tokens per vector line

	logic                                      clk;
	logic                                      rst_n;
	logic                                      issue;
	logic [`BE_STAGES-1:0]                     stall_vec, clr_vec;
	ctrl_flow_pkg::ctrl_flow_t                 ctrl_flow;
	data_flow_pkg::data_flow_t                 data_flow;
	data_flow_pkg::word_t [`BE_FWD_STAGES-1:0] other_pipe; // m1, m2, wb of pipe 1
	data_flow_pkg::word_t [`BE_FWD_STAGES-1:0] fwd_data;
	data_flow_pkg::fwd_src_t                   fwd_src;
	logic [`BE_REG_AW-1:0]                     reg_w_addr, exp_addr;
	data_flow_pkg::word_t                      reg_w_data, exp_data;
	logic [`BE_STAGES:0]                       revert_vector, exp_rev;
	logic                                      check_en;
	int                                        check_cnt, error_cnt;
	logic [31:0]                               vec_mem [0:NUM_VEC*VEC_COLS-1];

	assign fwd_src = {other_pipe, fwd_data}; // pipe 0 is our own result looped back

	always #50 clk = ~clk;

	backend_pipeline dut (
		.clk(clk), .rst_n(rst_n), .issue_i(issue), .stall_vec_i(stall_vec),
		.clr_vec_i(clr_vec), .ctrl_flow_i(ctrl_flow), .data_flow_i(data_flow),
		.forwarding_src_i(fwd_src), .forwarding_data_o(fwd_data),
		.reg_w_addr_o(reg_w_addr), .reg_w_data_o(reg_w_data), .revert_vector_o(revert_vector)
	);

	backend_checker u_checker (
		.clk(clk), .check_en_i(check_en), .stall_vec_i(stall_vec), .exp_addr_i(exp_addr),
		.exp_data_i(exp_data), .exp_rev_i(exp_rev), .reg_w_addr_i(reg_w_addr),
		.reg_w_data_i(reg_w_data), .revert_vector_i(revert_vector),
		.forwarding_data_i(fwd_data), .check_cnt_o(check_cnt), .error_cnt_o(error_cnt)
	);

	task automatic apply_vector(input int n);
		int b;
		b = n * VEC_COLS;
		issue                 = vec_mem[b][0];
		stall_vec             = vec_mem[b+1][`BE_STAGES-1:0];
		clr_vec               = vec_mem[b+2][`BE_STAGES-1:0];
		ctrl_flow.valid       = vec_mem[b][0];
		ctrl_flow.alu_op      = ctrl_flow_pkg::alu_op_e'(vec_mem[b+3][3:0]);
		ctrl_flow.use_imm     = vec_mem[b+4][0];
		ctrl_flow.w_reg       = vec_mem[b+5][`BE_REG_AW-1:0];
		ctrl_flow.revert      = vec_mem[b+6][0];
		ctrl_flow.fwd[0]      = ctrl_flow_pkg::fwd_info_t'(vec_mem[b+7][9:0]); // 10 bit info
		ctrl_flow.fwd[1]      = ctrl_flow_pkg::fwd_info_t'(vec_mem[b+8][9:0]);
		ctrl_flow.imm         = vec_mem[b+9];
		data_flow.pc          = vec_mem[b+10];
		data_flow.reg_data[0] = vec_mem[b+11];
		data_flow.reg_data[1] = vec_mem[b+12];
		data_flow.result      = '0;
		other_pipe[0]         = vec_mem[b+13];
		other_pipe[1]         = vec_mem[b+14];
		other_pipe[2]         = vec_mem[b+15];
		exp_addr              = vec_mem[b+16][`BE_REG_AW-1:0];
		exp_data              = vec_mem[b+17];
		exp_rev               = vec_mem[b+18][`BE_STAGES:0];
	endtask

	initial begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		check_en   = 1'b0;
		issue      = 1'b0;
		stall_vec  = '0;
		clr_vec    = '0;
		ctrl_flow  = '0;
		data_flow  = '0;
		other_pipe = '0;
		exp_addr   = '0;
		exp_data   = '0;
		exp_rev    = '0;
		$readmemh("dv/backend_vectors.txt", vec_mem);
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n    = 1'b1;
		check_en = 1'b1;
		for (int n = 0; n < NUM_VEC; n++) begin
			apply_vector(n);
			@(negedge clk);
		end
		check_en = 1'b0;
		$display("%0d checks, %0d errors", check_cnt, error_cnt);
		if (error_cnt == 0 && check_cnt == NUM_VEC) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// reset plus all vectors fit well inside this
	initial begin
		#((NUM_VEC + 40) * 100);
		$display("timeout: the vector run did not finish in time");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- dv/backend_checker.sv
`include "backend_settings.svh"

module backend_checker (
	input  logic                                      clk,
	input  logic                                      check_en_i,
	input  logic [`BE_STAGES-1:0]                     stall_vec_i,
	input  logic [`BE_REG_AW-1:0]                     exp_addr_i,
	input  data_flow_pkg::word_t                      exp_data_i,
	input  logic [`BE_STAGES:0]                       exp_rev_i,
	input  logic [`BE_REG_AW-1:0]                     reg_w_addr_i,
	input  data_flow_pkg::word_t                      reg_w_data_i,
	input  logic [`BE_STAGES:0]                       revert_vector_i,
	input  data_flow_pkg::word_t [`BE_FWD_STAGES-1:0] forwarding_data_i, // m1, m2, wb
	output int                                        check_cnt_o,
	output int                                        error_cnt_o
);

	int checks;
	int errors;
	int samples; // edges of history so far

	// earlier forwarding words, [0] is one edge back
	data_flow_pkg::word_t m1_seen [0:1];
	data_flow_pkg::word_t m2_seen;
	logic                 m2_held [0:1]; // m2 stall at those edges

	assign check_cnt_o = checks;
	assign error_cnt_o = errors;

	// 1 when the two values differ
	function automatic int compare_field(string name, logic [31:0] exp_v, logic [31:0] act_v);
		if (exp_v !== act_v) begin
			$display("Mismatch at %0t: %s expected %h, actual %h", $time, name, exp_v, act_v);
			return 1;
		end
		return 0;
	endfunction

	initial begin
		checks  = 0;
		errors  = 0;
		samples = 0;
	end

	// outputs here are still the values from before this edge
	always @(posedge clk) begin
		if (check_en_i) begin
			checks = checks + 1;
			errors = errors + compare_field("reg_w_addr_o", 32'(exp_addr_i), 32'(reg_w_addr_i));
			errors = errors + compare_field("revert_vector_o", 32'(exp_rev_i),
			                                32'(revert_vector_i));
			if (exp_addr_i != '0) begin
				errors = errors + compare_field("reg_w_data_o", exp_data_i, reg_w_data_i); // write only
				errors = errors + compare_field("forwarding_data_o[2]", exp_data_i,
				                                forwarding_data_i[2]);
				// same result sat in m2 one edge ago, in m1 the edge before
				if (samples > 0) begin
					errors = errors + compare_field("forwarding_data_o[1]", exp_data_i, m2_seen);
				end
				if (samples > 1 && !m2_held[1]) begin
					errors = errors + compare_field("forwarding_data_o[0]", exp_data_i,
					                                m1_seen[1]);
				end
			end
			m1_seen[1] = m1_seen[0];
			m1_seen[0] = forwarding_data_i[0];
			m2_seen    = forwarding_data_i[1];
			m2_held[1] = m2_held[0];
			m2_held[0] = stall_vec_i[2];
			samples    = samples + 1;
		end
	end

endmodule

//--- backend/backend_pipeline.sv
`include "backend_settings.svh"

module backend_pipeline (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  logic                                      issue_i,
	input  logic [`BE_STAGES-1:0]                     stall_vec_i,
	input  logic [`BE_STAGES-1:0]                     clr_vec_i,
	input  ctrl_flow_pkg::ctrl_flow_t                 ctrl_flow_i,
	input  data_flow_pkg::data_flow_t                 data_flow_i,
	input  data_flow_pkg::fwd_src_t                   forwarding_src_i,
	output data_flow_pkg::word_t [`BE_FWD_STAGES-1:0] forwarding_data_o, // m1, m2, wb
	output logic [`BE_REG_AW-1:0]                     reg_w_addr_o,
	output data_flow_pkg::word_t                      reg_w_data_o,
	output logic [`BE_STAGES:0]                       revert_vector_o // wb, m2, m1, ex
);

	ctrl_flow_pkg::ctrl_flow_t ex_ctrl, m1_ctrl, m2_ctrl, wb_ctrl;
	data_flow_pkg::data_flow_t ex_raw, m1_raw, m2_raw, wb_data;
	data_flow_pkg::data_flow_t ex_opnd, ex_fwd, m1_fwd, m2_fwd;
	data_flow_pkg::word_t      ex_result;

	// later stages only see the sources still ahead of them
	data_flow_pkg::word_t [`BE_PIPES-1:0][1:0] m1_srcs; // m2, wb
	data_flow_pkg::word_t [`BE_PIPES-1:0][0:0] m2_srcs; // wb

	for (genvar p = 0; p < `BE_PIPES; p++) begin : g_src
		assign m1_srcs[p] = forwarding_src_i[p][2:1];
		assign m2_srcs[p] = forwarding_src_i[p][2:2];
	end

	stage_ctrl_regs u_ctrl (
		.clk(clk), .rst_n(rst_n), .issue_i(issue_i),
		.stall_vec_i(stall_vec_i), .clr_vec_i(clr_vec_i), .ctrl_flow_i(ctrl_flow_i),
		.ex_ctrl_o(ex_ctrl), .m1_ctrl_o(m1_ctrl), .m2_ctrl_o(m2_ctrl), .wb_ctrl_o(wb_ctrl)
	);

	stage_data_regs u_data (
		.clk(clk), .data_flow_i(data_flow_i), .stall_vec_i(stall_vec_i),
		.ex_fwd_i(ex_fwd), .m1_fwd_i(m1_fwd), .m2_fwd_i(m2_fwd),
		.ex_raw_o(ex_raw), .m1_raw_o(m1_raw), .m2_raw_o(m2_raw), .wb_data_o(wb_data)
	);

	for (genvar r = 0; r < `BE_SRC_REGS; r++) begin : g_fwd
		operand_forward #(.SRC_NUM(3)) u_ex_fwd (
			.pipe_sel_i(ex_ctrl.fwd[r].pipe_sel), .sel_vec_i(ex_ctrl.fwd[r].ex_src),
			.src_i(forwarding_src_i), .old_i(ex_raw.reg_data[r]),
			.new_o(ex_opnd.reg_data[r])
		);
		operand_forward #(.SRC_NUM(2)) u_m1_fwd (
			.pipe_sel_i(m1_ctrl.fwd[r].pipe_sel), .sel_vec_i(m1_ctrl.fwd[r].m1_src),
			.src_i(m1_srcs), .old_i(m1_raw.reg_data[r]), .new_o(m1_fwd.reg_data[r])
		);
		operand_forward #(.SRC_NUM(1)) u_m2_fwd (
			.pipe_sel_i(m2_ctrl.fwd[r].pipe_sel), .sel_vec_i(m2_ctrl.fwd[r].m2_src),
			.src_i(m2_srcs), .old_i(m2_raw.reg_data[r]), .new_o(m2_fwd.reg_data[r])
		);
	end

	assign ex_opnd.pc     = ex_raw.pc;
	assign ex_opnd.result = ex_raw.result;

	exec_unit u_exec (.ctrl_i(ex_ctrl), .opnd_i(ex_opnd), .result_o(ex_result));

	always_comb begin
		ex_fwd        = ex_opnd;
		ex_fwd.result = ex_result;
	end

	// m1 and m2 only carry the ex result forward
	assign m1_fwd.pc     = m1_raw.pc;
	assign m1_fwd.result = m1_raw.result;
	assign m2_fwd.pc     = m2_raw.pc;
	assign m2_fwd.result = m2_raw.result;

	assign forwarding_data_o = {wb_data.result, m2_raw.result, m1_raw.result};
	assign reg_w_addr_o      = wb_ctrl.valid ? wb_ctrl.w_reg : '0;
	assign reg_w_data_o      = wb_data.result;
	assign revert_vector_o   = {wb_ctrl.revert, m2_ctrl.revert, m1_ctrl.revert, ex_ctrl.revert};

endmodule

//--- backend/stage_data_regs.sv
`include "backend_settings.svh"

module stage_data_regs (
	input  logic                      clk,
	input  data_flow_pkg::data_flow_t data_flow_i,
	input  logic [`BE_STAGES-1:0]     stall_vec_i, // ex, m1, m2
	input  data_flow_pkg::data_flow_t ex_fwd_i,
	input  data_flow_pkg::data_flow_t m1_fwd_i,
	input  data_flow_pkg::data_flow_t m2_fwd_i,
	output data_flow_pkg::data_flow_t ex_raw_o,
	output data_flow_pkg::data_flow_t m1_raw_o,
	output data_flow_pkg::data_flow_t m2_raw_o,
	output data_flow_pkg::data_flow_t wb_data_o
);

	// a stalled stage keeps its forwarded operands so the source may move on
	always_ff @(posedge clk) begin
		if (stall_vec_i[0]) begin
			ex_raw_o <= ex_fwd_i;
		end else begin
			ex_raw_o <= data_flow_i;
		end
	end

	always_ff @(posedge clk) begin
		if (stall_vec_i[1]) begin
			m1_raw_o <= m1_fwd_i;
		end else begin
			m1_raw_o <= ex_fwd_i; // carries the ALU result
		end
	end

	always_ff @(posedge clk) begin
		if (stall_vec_i[2]) begin
			m2_raw_o <= m2_fwd_i;
		end else begin
			m2_raw_o <= m1_fwd_i;
		end
	end

	always_ff @(posedge clk) begin
		wb_data_o <= m2_fwd_i;
	end

endmodule

//--- backend/stage_ctrl_regs.sv
`include "backend_settings.svh"

module stage_ctrl_regs (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      issue_i,
	input  logic [`BE_STAGES-1:0]     stall_vec_i, // ex, m1, m2
	input  logic [`BE_STAGES-1:0]     clr_vec_i,
	input  ctrl_flow_pkg::ctrl_flow_t ctrl_flow_i,
	output ctrl_flow_pkg::ctrl_flow_t ex_ctrl_o,
	output ctrl_flow_pkg::ctrl_flow_t m1_ctrl_o,
	output ctrl_flow_pkg::ctrl_flow_t m2_ctrl_o,
	output ctrl_flow_pkg::ctrl_flow_t wb_ctrl_o
);

	// ex stage
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_ctrl_o <= '0;
		end else if (!stall_vec_i[0]) begin
			ex_ctrl_o <= issue_i ? ctrl_flow_i : '0;
		end else begin
			// stalled, so follow the producer as it moves down the pipe
			for (int i = 0; i < `BE_SRC_REGS; i++) begin
				if ((!stall_vec_i[1] && ex_ctrl_o.fwd[i].ex_src[1]) ||
				    (!stall_vec_i[2] && ex_ctrl_o.fwd[i].ex_src[2]) ||
				    ex_ctrl_o.fwd[i].ex_src[3]) begin
					ex_ctrl_o.fwd[i].ex_src <= {ex_ctrl_o.fwd[i].ex_src[2:1], 1'b0,
					                            ~|ex_ctrl_o.fwd[i].ex_src[2:1]};
					ex_ctrl_o.fwd[i].m1_src <= {ex_ctrl_o.fwd[i].m1_src[1], 1'b0,
					                            ~ex_ctrl_o.fwd[i].m1_src[1]};
					ex_ctrl_o.fwd[i].m2_src <= 2'b01;
				end
			end
		end
	end

	// m1 stage
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m1_ctrl_o <= '0;
		end else if (!stall_vec_i[1]) begin
			if (clr_vec_i[0] || stall_vec_i[0]) begin
				m1_ctrl_o <= '0; // bubble
			end else begin
				m1_ctrl_o <= ex_ctrl_o;
			end
		end else begin
			for (int i = 0; i < `BE_SRC_REGS; i++) begin
				if ((!stall_vec_i[2] && m1_ctrl_o.fwd[i].m1_src[1]) ||
				    m1_ctrl_o.fwd[i].m1_src[2]) begin
					m1_ctrl_o.fwd[i].m1_src <= {m1_ctrl_o.fwd[i].m1_src[1], 1'b0,
					                            ~m1_ctrl_o.fwd[i].m1_src[1]};
					m1_ctrl_o.fwd[i].m2_src <= 2'b01;
				end
			end
		end
	end

	// m2 stage
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m2_ctrl_o <= '0;
		end else if (!stall_vec_i[2]) begin
			if (clr_vec_i[1] || stall_vec_i[1]) begin
				m2_ctrl_o <= '0;
			end else begin
				m2_ctrl_o <= m1_ctrl_o;
			end
		end else begin
			for (int i = 0; i < `BE_SRC_REGS; i++) begin
				if (m2_ctrl_o.fwd[i].m2_src[1]) begin
					m2_ctrl_o.fwd[i].m2_src <= 2'b01; // wb value now captured
				end
			end
		end
	end

	// wb never stalls
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ctrl_o <= '0;
		end else if (clr_vec_i[2] || stall_vec_i[2]) begin
			wb_ctrl_o <= '0;
		end else begin
			wb_ctrl_o <= m2_ctrl_o;
		end
	end

	// holds across issue, advance and every retarget step
	for (genvar i = 0; i < `BE_SRC_REGS; i++) begin : g_src_chk
		a_src_onehot: assert property (@(posedge clk) disable iff (!rst_n)
			$onehot0(ex_ctrl_o.fwd[i].ex_src) && $onehot0(m1_ctrl_o.fwd[i].m1_src) &&
			$onehot0(m2_ctrl_o.fwd[i].m2_src))
			else $error("stored forward source %0d not one-hot", i);
	end

endmodule

//--- design/exec_unit.sv
`include "backend_settings.svh"

module exec_unit (
	input  ctrl_flow_pkg::ctrl_flow_t ctrl_i,
	input  data_flow_pkg::data_flow_t opnd_i,
	output data_flow_pkg::word_t      result_o
);

	data_flow_pkg::word_t src_a;
	data_flow_pkg::word_t src_b;

	assign src_a = opnd_i.reg_data[0];
	assign src_b = ctrl_i.use_imm ? ctrl_i.imm : opnd_i.reg_data[1];

	always_comb begin
		case (ctrl_i.alu_op)
			ctrl_flow_pkg::ALU_ADD: begin
				result_o = src_a + src_b;
			end
			ctrl_flow_pkg::ALU_SUB: begin
				result_o = src_a - src_b;
			end
			ctrl_flow_pkg::ALU_AND: result_o = src_a & src_b;
			ctrl_flow_pkg::ALU_OR:  result_o = src_a | src_b;
			ctrl_flow_pkg::ALU_XOR: result_o = src_a ^ src_b;
			ctrl_flow_pkg::ALU_SLT: begin
				result_o = data_flow_pkg::word_t'($signed(src_a) < $signed(src_b));
			end
			ctrl_flow_pkg::ALU_SLTU: begin
				result_o = data_flow_pkg::word_t'(src_a < src_b);
			end
			ctrl_flow_pkg::ALU_LUI: begin
				result_o = ctrl_i.imm; // imm arrives already shifted
			end
			ctrl_flow_pkg::ALU_LINK: begin
				// return address for calls
				result_o = opnd_i.pc + data_flow_pkg::word_t'(4);
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

//--- design/operand_forward.sv
`include "backend_settings.svh"

module operand_forward #(
	parameter int SRC_NUM = 3
) (
	input  logic                                           pipe_sel_i,
	input  logic [SRC_NUM:0]                               sel_vec_i,
	input  data_flow_pkg::word_t [`BE_PIPES-1:0][SRC_NUM-1:0] src_i,
	input  data_flow_pkg::word_t                           old_i,
	output data_flow_pkg::word_t                           new_o
);

	// bit0 or an empty vector keeps the old operand
	always_comb begin
		new_o = old_i;
		for (int i = 1; i <= SRC_NUM; i++) begin
			if (sel_vec_i[i]) begin
				new_o = src_i[pipe_sel_i][i-1];
			end
		end
	end

	// the select comes from the control registers after retargeting
	always_comb begin
		if (!$isunknown(sel_vec_i)) begin
			a_sel_onehot: assert ($onehot0(sel_vec_i))
				else $error("forward select not one-hot: %b", sel_vec_i);
		end
	end

endmodule

//--- common/data_flow_pkg.sv
`include "backend_settings.svh"

package data_flow_pkg;

	typedef logic [`BE_XLEN-1:0] word_t;

	typedef struct packed {
		word_t                    pc;
		word_t [`BE_SRC_REGS-1:0] reg_data;
		word_t                    result;
	} data_flow_t;

	// [pipe][stage], stage 0 m1, 1 m2, 2 wb
	typedef word_t [`BE_PIPES-1:0][`BE_FWD_STAGES-1:0] fwd_src_t;

endpackage

//--- common/ctrl_flow_pkg.sv
`include "backend_settings.svh"

package ctrl_flow_pkg;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLT  = 4'd5,
		ALU_SLTU = 4'd6,
		ALU_LUI  = 4'd7, // passes imm
		ALU_LINK = 4'd8  // pc + 4
	} alu_op_e;

	// one-hot source vectors, bit0 always means keep the held value
	typedef struct packed {
		logic                      pipe_sel; // 0 own pipe, 1 other pipe
		logic [`BE_FWD_STAGES:0]   ex_src;   // keep, m1, m2, wb
		logic [`BE_FWD_STAGES-1:0] m1_src;   // keep, m2, wb
		logic [`BE_FWD_STAGES-2:0] m2_src;   // keep, wb
	} fwd_info_t;

	typedef struct packed {
		logic                         valid;
		alu_op_e                      alu_op;
		logic                         use_imm; // operand 1 replaced by imm
		logic [`BE_XLEN-1:0]          imm;
		logic [`BE_REG_AW-1:0]        w_reg;   // zero means no write
		logic                         revert;
		fwd_info_t [`BE_SRC_REGS-1:0] fwd;
	} ctrl_flow_t;

endpackage

//--- common/backend_settings.svh
`ifndef BACKEND_SETTINGS_SVH
`define BACKEND_SETTINGS_SVH

// datapath widths
`define BE_XLEN 32
`define BE_REG_AW 5

// operands per instruction
`define BE_SRC_REGS 2

// forwarding network shape
`define BE_PIPES 2
`define BE_FWD_STAGES 3 // m1, m2, wb
`define BE_STAGES 3 // ex, m1, m2 have stall/clear

`endif
